// File: include/recip_defines.svh
//******************************
// recip defines: Q format widths
// and register byte offsets
//******************************
`ifndef RECIP_DEFINES_SVH
`define RECIP_DEFINES_SVH

// integer and fraction bits of the fixed point format
`define RECIP_QM 11
`define RECIP_QN 11
`define RECIP_W (`RECIP_QM + `RECIP_QN)

// leading zero count must hold 0..RECIP_W
`define RECIP_LZC_W 5

// axi4-lite register offsets
`define RECIP_REG_CTRL 4'h0
`define RECIP_REG_OPERAND 4'h4
`define RECIP_REG_STATUS 4'h8
`define RECIP_REG_RESULT 4'hC

`endif

// File: recip_top.f
+incdir+include
src/recip_pkg.sv
src/lzc.sv
src/recip_normalizer.sv
src/recip_divider.sv
src/recip_ctrl.sv
src/recip_top.sv
testbench/recip_tb.sv

// File: src/lzc.sv
//******************************
// lzc: leading zero counter over
// the operand magnitude
//******************************
`timescale 1ns/1ps
`include "recip_defines.svh"

module lzc (
  input  logic [`RECIP_W:0]       data,
  output logic [`RECIP_LZC_W-1:0] count
);

  always_comb begin
    // all zero gives the full width
    count = `RECIP_LZC_W'(`RECIP_W);
    // scan upward so the highest set bit is the last to win
    for (int i = 0; i < `RECIP_W; i++) begin
      if (data[i]) begin
        count = `RECIP_LZC_W'(`RECIP_W - 1 - i);
      end
    end
    // headroom bit set means nothing leads it
    if (data[`RECIP_W]) begin
      count = '0;
    end
  end

endmodule

// File: src/recip_ctrl.sv
//******************************
// recip ctrl: axi4-lite slave,
// registers and operation FSM
//******************************
`timescale 1ns/1ps
`include "recip_defines.svh"

module recip_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [3:0]               awaddr,
  input  logic                     wvalid,
  output logic                     wready,
  input  logic [31:0]              wdata,
  output logic                     bvalid,
  input  logic                     bready,
  output logic [1:0]               bresp,
  input  logic                     arvalid,
  output logic                     arready,
  input  logic [3:0]               araddr,
  output logic                     rvalid,
  input  logic                     rready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  input  recip_pkg::recip_norm_t   norm,
  output logic [`RECIP_W-1:0]      operand,
  output logic                     div_start,
  output recip_pkg::recip_norm_t   div_norm,
  input  logic                     div_done,
  input  recip_pkg::recip_result_t div_result
);
  import recip_pkg::*;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  recip_state_e  state;
  recip_op_e     op;
  recip_result_t result;
  logic          busy;
  logic          done;
  logic          wr_en;
  logic          wr_ctrl;
  logic          start_req;
  logic          reject;
  logic          rd_en;
  logic [31:0]   rd_word;

  assign busy      = (state == ST_NORM) || (state == ST_DIV);
  assign done      = (state == ST_DONE);
  assign wr_en     = awready && awvalid && wvalid;
  assign wr_ctrl   = wr_en && (awaddr == `RECIP_REG_CTRL);
  assign start_req = wr_ctrl && wdata[0];
  assign reject    = start_req && busy;
  assign rd_en     = arready && arvalid;
  assign rresp     = RESP_OKAY;

  // write address and data are taken in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !bvalid && !awready;
      wready  <= awvalid && wvalid && !bvalid && !awready;
      if (wr_en) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      bresp <= reject ? RESP_SLVERR : RESP_OKAY;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      op <= OP_LZC;
    end else if (wr_ctrl && !reject) begin
      op <= recip_op_e'(wdata[5:4]);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && awaddr == `RECIP_REG_OPERAND) begin
      operand <= wdata[`RECIP_W-1:0];
    end
  end

  // done is ST_DONE, so a new start clears it
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      div_start <= 1'b0;
    end else begin
      div_start <= 1'b0;
      case (state)
        ST_IDLE, ST_DONE: begin
          if (start_req) begin
            state <= ST_NORM;
          end
        end
        ST_NORM: begin
          if (op == OP_RECIP) begin
            state     <= ST_DIV;
            div_start <= 1'b1;
          end else begin
            state <= ST_DONE;
          end
        end
        ST_DIV: begin
          if (div_done) begin
            state <= ST_DONE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_NORM) begin
      div_norm     <= norm;
      result.value <= (op == OP_NORM) ? norm.norm : `RECIP_W'(norm.lzc);
      result.sat   <= 1'b0;
    end else if (state == ST_DIV && div_done) begin
      result <= div_result;
    end
  end

  always_comb begin
    case (araddr)
      `RECIP_REG_CTRL:    rd_word = {26'd0, op, 4'd0};
      `RECIP_REG_OPERAND: rd_word = {{(32-`RECIP_W){1'b0}}, operand};
      `RECIP_REG_STATUS:  rd_word = {29'd0, done && result.sat, done, busy};
      `RECIP_REG_RESULT:  rd_word = {{(32-`RECIP_W){result.value[`RECIP_W-1]}}, result.value};
      default:            rd_word = '0;
    endcase
  end

  // arready drops while a read response is pending
  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else if (rd_en) begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
    end else if (rvalid) begin
      if (rready) begin
        rvalid  <= 1'b0;
        arready <= 1'b1;
      end
    end else begin
      arready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= rd_word;
    end
  end

  assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid);

  assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: src/recip_divider.sv
//******************************
// recip divider: restoring divide
// of 2^W by |x|, saturated, signed
//******************************
`timescale 1ns/1ps
`include "recip_defines.svh"

module recip_divider (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  recip_pkg::recip_norm_t   norm,
  output logic                     done,
  output recip_pkg::recip_result_t result
);
  import recip_pkg::*;

  localparam logic [`RECIP_W-1:0] SAT_POS = {1'b0, {(`RECIP_W-1){1'b1}}};

  logic                    busy;
  logic                    sign;
  logic                    tiny;
  logic [`RECIP_LZC_W-1:0] cnt;
  logic [`RECIP_W:0]       divisor;
  logic [`RECIP_W:0]       rem;
  logic [`RECIP_W:0]       rem_sh;
  logic [`RECIP_W:0]       rem_next;
  logic                    q_bit;
  logic [`RECIP_W-1:0]     quo;
  logic [`RECIP_W-1:0]     quo_next;

  function automatic recip_result_t pack_result(input logic neg,
                                                input logic [`RECIP_W-1:0] q,
                                                input logic force_sat);
    recip_result_t r;
    r.sat = force_sat || (q > SAT_POS);
    if (r.sat) begin
      r.value = neg ? -SAT_POS : SAT_POS;
    end else begin
      r.value = neg ? -q : q;
    end
    return r;
  endfunction

  // magnitude 0 or 1 always saturates without iterating
  assign tiny = (norm.mag < 2);

  // one restoring step
  always_comb begin
    rem_sh   = rem << 1;
    q_bit    = (rem_sh >= divisor);
    rem_next = q_bit ? rem_sh - divisor : rem_sh;
    quo_next = {quo[`RECIP_W-2:0], q_bit};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= !tiny;
        done <= tiny;
      end else if (busy && cnt == '0) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sign    <= norm.sign;
      divisor <= norm.mag;
      // partial remainder of 2^W above the first quotient bit that can be set
      rem     <= {{`RECIP_W{1'b0}}, 1'b1} << (`RECIP_W - 2 - norm.lzc);
      quo     <= '0;
      // lzc+2 quotient bits
      cnt     <= norm.lzc + `RECIP_LZC_W'(1);
      result  <= pack_result(norm.sign, '0, tiny);
    end else if (busy) begin
      rem <= rem_next;
      quo <= quo_next;
      cnt <= cnt - `RECIP_LZC_W'(1);
      if (cnt == '0) begin
        result <= pack_result(sign, quo_next, 1'b0);
      end
    end
  end

  // the controller must wait for done before launching again
  assert property (@(posedge clk) disable iff (reset) busy |-> !start);

endmodule

// File: src/recip_normalizer.sv
//******************************
// recip normalizer: sign, magnitude,
// lzc and left-aligned magnitude
//******************************
`timescale 1ns/1ps
`include "recip_defines.svh"

module recip_normalizer (
  input  logic [`RECIP_W-1:0]  operand,
  output recip_pkg::recip_norm_t norm
);

  logic                    sign;
  logic [`RECIP_W:0]       mag;
  logic [`RECIP_LZC_W-1:0] count;
  logic [`RECIP_W-1:0]     shifted;

  assign sign = operand[`RECIP_W-1];

  // two's complement negate into the wider magnitude
  assign mag = sign ? {1'b0, ~operand} + 1'b1 : {1'b0, operand};

  lzc lzc_i (
    .data  (mag),
    .count (count)
  );

  // a count of RECIP_W shifts everything out, so zero stays zero
  assign shifted = mag[`RECIP_W-1:0] << count;

  always_comb begin
    norm.sign = sign;
    norm.mag  = mag;
    norm.lzc  = count;
    norm.norm = shifted;
  end

endmodule

// File: src/recip_pkg.sv
//******************************
// recip package: opcodes, FSM
// states and datapath structs
//******************************
`include "recip_defines.svh"

package recip_pkg;

  // opcode field of CTRL bits 5:4
  typedef enum logic [1:0] {
    OP_LZC   = 2'd0,
    OP_NORM  = 2'd1,
    OP_RECIP = 2'd2
  } recip_op_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_NORM = 2'd1,
    ST_DIV  = 2'd2,
    ST_DONE = 2'd3
  } recip_state_e;

  // sign/magnitude split of the operand plus its normalized form
  // mag is one bit wider so the most negative operand still fits
  typedef struct packed {
    logic                    sign;
    logic [`RECIP_W:0]       mag;
    logic [`RECIP_LZC_W-1:0] lzc;
    logic [`RECIP_W-1:0]     norm;
  } recip_norm_t;

  typedef struct packed {
    logic [`RECIP_W-1:0] value;
    logic                sat;
  } recip_result_t;

endpackage

// File: src/recip_top.sv
//******************************
// recip top: control plus the
// normalizer and divider datapath
//******************************
`timescale 1ns/1ps
`include "recip_defines.svh"

module recip_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        awvalid,
  output logic        awready,
  input  logic [3:0]  awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  input  logic        arvalid,
  output logic        arready,
  input  logic [3:0]  araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp
);
  import recip_pkg::*;

  logic [`RECIP_W-1:0] operand;
  recip_norm_t         norm;
  logic                div_start;
  recip_norm_t         div_norm;
  logic                div_done;
  recip_result_t       div_result;

  recip_ctrl recip_ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .norm       (norm),
    .operand    (operand),
    .div_start  (div_start),
    .div_norm   (div_norm),
    .div_done   (div_done),
    .div_result (div_result)
  );

  recip_normalizer recip_normalizer_i (
    .operand (operand),
    .norm    (norm)
  );

  recip_divider recip_divider_i (
    .clk    (clk),
    .reset  (reset),
    .start  (div_start),
    .norm   (div_norm),
    .done   (div_done),
    .result (div_result)
  );

endmodule

// File: testbench/recip_cases.txt
# opcode (0 lzc, 1 norm, 2 recip)  operand (22-bit hex)  RESULT (32-bit hex)  sat
# RESULT is the register word, sign-extended from 22 bits
0 000000 00000016 0
0 000001 00000015 0
0 000800 0000000a 0
0 3ff800 0000000a 0
0 200000 00000000 0
0 1fffff 00000001 0
1 000000 00000000 0
1 000001 ffe00000 0
1 000800 ffe00000 0
1 3ff400 fff00000 0
1 000123 ffe46000 0
2 000800 00000800 0
2 000000 001fffff 1
2 000001 001fffff 1
2 3fffff ffe00001 1
2 000002 001fffff 1
2 3ffffe ffe00001 1
2 000003 00155555 0
2 3ff800 fffff800 0
2 001000 00000400 0
2 200000 fffffffe 0
2 1fffff 00000002 0
2 000c00 00000555 0
2 000400 00001000 0

// File: testbench/recip_tb.sv
//******************************
// recip testbench: axi4-lite
// driver checking the cases file
//******************************
`timescale 1ns/1ps
`include "recip_defines.svh"

module recip_tb;
  import recip_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int MAX_POLLS = 64;

  logic        clk;
  logic        reset;
  logic        awvalid;
  logic        awready;
  logic [3:0]  awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [3:0]  araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  integer      seed;
  int          errors;
  int          checks;
  int          timeouts;
  int          n_case;
  int          fd;
  int          code;
  string       line;
  int          c_op;
  logic [31:0] c_operand;
  logic [31:0] c_expect;
  int          c_sat;
  logic [31:0] data;
  logic [31:0] value;
  logic [1:0]  resp;
  int          op;

  recip_top recip_top_i (
    .clk     (clk),
    .reset   (reset),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  always #20 clk = ~clk;

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string channel);
    $display("timeout at %0d ns: no handshake on the %s channel", $time, channel);
    timeouts++;
    errors++;
  endtask

  // 0 to 3 idle cycles before a ready is raised
  task automatic random_delay();
    int d;
    d = $unsigned($random(seed)) % 4;
    repeat (d) @(posedge clk);
  endtask

  task automatic bus_write(input logic [3:0] addr, input logic [31:0] wr, output logic [1:0] rsp);
    int t;
    rsp = 2'b11;
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= wr;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!(awready && wready) && t < TIMEOUT);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!(awready && wready)) begin
      report_timeout("write address and data");
      return;
    end
    t = 0;
    while (!bvalid && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (!bvalid) begin
      report_timeout("write response");
      return;
    end
    random_delay();
    bready <= 1'b1;
    @(posedge clk);
    rsp = bresp;
    bready <= 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] addr, output logic [31:0] rd, output logic [1:0] rsp);
    int t;
    rd  = '0;
    rsp = 2'b11;
    arvalid <= 1'b1;
    araddr  <= addr;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!arready && t < TIMEOUT);
    arvalid <= 1'b0;
    if (!arready) begin
      report_timeout("read address");
      return;
    end
    t = 0;
    while (!rvalid && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (!rvalid) begin
      report_timeout("read data");
      return;
    end
    random_delay();
    rready <= 1'b1;
    @(posedge clk);
    rd  = rdata;
    rsp = rresp;
    rready <= 1'b0;
  endtask

  // poll STATUS until done and return the last STATUS word
  task automatic wait_done(output logic [31:0] status);
    logic [1:0] rsp;
    int         n;
    n = 0;
    do begin
      bus_read(`RECIP_REG_STATUS, status, rsp);
      n++;
    end while (!status[1] && n < MAX_POLLS);
    if (!status[1]) begin
      $display("timeout at %0d ns: done never set in STATUS", $time);
      timeouts++;
      errors++;
    end
  endtask

  task automatic run_case(input int cop, input logic [31:0] opnd, input logic [31:0] exp,
                          input int sat, input int idx);
    logic [1:0]  rsp;
    logic [31:0] rd;
    bus_write(`RECIP_REG_OPERAND, opnd, rsp);
    check_value(rsp, 2'b00, $sformatf("case %0d operand bresp", idx));
    bus_write(`RECIP_REG_CTRL, (cop << 4) | 1, rsp);
    check_value(rsp, 2'b00, $sformatf("case %0d start bresp", idx));
    wait_done(rd);
    check_value(rd[0], 1'b0, $sformatf("case %0d busy after done", idx));
    check_value(rd[2], sat[0], $sformatf("case %0d sat", idx));
    bus_read(`RECIP_REG_RESULT, rd, rsp);
    check_value(rd, exp, $sformatf("case %0d op %0d operand %h result", idx, cop, opnd));
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    awvalid  = 1'b0;
    awaddr   = '0;
    wvalid   = 1'b0;
    wdata    = '0;
    bready   = 1'b0;
    arvalid  = 1'b0;
    araddr   = '0;
    rready   = 1'b0;
    seed     = 32'hff4e_b019;
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    n_case   = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // idle state straight out of reset
    bus_read(`RECIP_REG_STATUS, data, resp);
    check_value(data, 32'h0, "status after reset");
    check_value(resp, 2'b00, "status rresp");
    bus_read(4'h6, data, resp);
    check_value(data, 32'h0, "unmapped offset read");
    check_value(resp, 2'b00, "unmapped offset rresp");

    fd = $fopen("testbench/recip_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file testbench/recip_cases.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && $sscanf(line, "%d %h %h %d", c_op, c_operand, c_expect, c_sat) == 4) begin
          n_case++;
          run_case(c_op, c_operand, c_expect, c_sat, n_case);
        end
      end
      $fclose(fd);
      if (n_case == 0) begin
        $display("the cases file held no usable lines");
        errors++;
      end
    end

    // second start while the divider runs must be refused
    bus_write(`RECIP_REG_OPERAND, 32'h3, resp);
    bus_write(`RECIP_REG_CTRL, {26'd0, OP_RECIP, 4'h1}, resp);
    check_value(resp, 2'b00, "recip start bresp");
    bus_write(`RECIP_REG_CTRL, {26'd0, OP_LZC, 4'h1}, resp);
    check_value(resp, 2'b10, "start while busy bresp");
    wait_done(data);
    bus_read(`RECIP_REG_RESULT, data, resp);
    check_value(data, 32'h0015_5555, "result after refused start");
    bus_read(`RECIP_REG_CTRL, data, resp);
    check_value(data, 32'h20, "opcode after refused start");

    // register readback across random ready delays
    repeat (8) begin
      value = $random(seed);
      op = $unsigned($random(seed)) % 3;
      bus_write(`RECIP_REG_OPERAND, value, resp);
      bus_read(`RECIP_REG_OPERAND, data, resp);
      check_value(data, value & 32'h003f_ffff, "operand readback");
      bus_write(`RECIP_REG_CTRL, op << 4, resp);
      bus_read(`RECIP_REG_CTRL, data, resp);
      check_value(data, op << 4, "ctrl readback");
    end

    $display("cases: %0d  checks: %0d  errors: %0d  timeouts: %0d",
             n_case, checks, errors, timeouts);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
